//--- design/ex_pkg.sv
////////////////////////////////////////
// Widths, opcodes and packed bundles shared by the execute stage
// Design modules import this package inside their bodies
////////////////////////////////////////
package ex_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Integer datapath width
  localparam int unsigned xlen = 32;
  // Register file address width
  localparam int unsigned reg_addr_w = 5;
  // Shift amount taken from operand b
  localparam int unsigned shamt_w = 5;

  ////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////

  // ALU operations, comparisons last
  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_and  = 4'd2,
    alu_or   = 4'd3,
    alu_xor  = 4'd4,
    alu_sll  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_slt  = 4'd8,
    alu_sltu = 4'd9,
    alu_eq   = 4'd10,
    alu_ne   = 4'd11,
    alu_lt   = 4'd12,
    alu_ge   = 4'd13
  } alu_op_e;

  // Low word in one cycle, signed high word in two
  typedef enum logic {
    mult_mul  = 1'b0,
    mult_mulh = 1'b1
  } mult_op_e;

  ////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////

  // ALU request from decode; c is the jump target
  typedef struct packed {
    logic            en;
    alu_op_e         op;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] c;
  } alu_req_t;

  // Multiplier request from decode
  typedef struct packed {
    logic            en;
    mult_op_e        op;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
  } mult_req_t;

  // Response of one multiplier replica, also the voted response
  typedef struct packed {
    logic [xlen-1:0] result;
    logic            ready;
    logic            mulh_active;
  } mult_rsp_t;

  // One register file write port
  typedef struct packed {
    logic                  we;
    logic [reg_addr_w-1:0] addr;
    logic [xlen-1:0]       data;
  } reg_wr_t;

endpackage

//--- design/ex_alu.sv
////////////////////////////////////////
// Integer ALU of the execute stage
// Produces the arithmetic result and the branch comparison flag
////////////////////////////////////////
`timescale 1ns/1ps

module ex_alu (
  input  logic                    clk,
  input  logic                    rst_n,
  input  ex_pkg::alu_req_t        req_i,
  output logic [ex_pkg::xlen-1:0] result_o,
  output logic                    cmp_o,
  output logic                    ready_o
);
  import ex_pkg::*;

  // Shift amount from the low bits of b
  logic [shamt_w-1:0] shamt;
  // Shared comparator outputs
  logic               eq;
  logic               lt_s;
  logic               lt_u;
  // Operands usable once the stage is out of reset
  logic               op_valid_q;

  assign shamt = req_i.b[shamt_w-1:0];
  assign eq    = (req_i.a == req_i.b);
  assign lt_s  = ($signed(req_i.a) < $signed(req_i.b));
  assign lt_u  = (req_i.a < req_i.b);

  ////////////////////////////////////////
  // Comparison
  ////////////////////////////////////////

  // Branch and set-less-than share one comparator
  always_comb begin
    case (req_i.op)
      alu_eq:          cmp_o = eq;
      alu_ne:          cmp_o = !eq;
      alu_lt, alu_slt: cmp_o = lt_s;
      alu_ge:          cmp_o = !lt_s;
      alu_sltu:        cmp_o = lt_u;
      default:         cmp_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // Result
  ////////////////////////////////////////

  always_comb begin
    case (req_i.op)
      alu_add: result_o = req_i.a + req_i.b;
      alu_sub: result_o = req_i.a - req_i.b;
      alu_and: result_o = req_i.a & req_i.b;
      alu_or:  result_o = req_i.a | req_i.b;
      alu_xor: result_o = req_i.a ^ req_i.b;
      alu_sll: result_o = req_i.a << shamt;
      alu_srl: result_o = req_i.a >> shamt;
      // Arithmetic shift keeps the sign of a
      alu_sra: result_o = $unsigned($signed(req_i.a) >>> shamt);
      // Comparisons write the flag zero extended
      default: result_o = {{(xlen-1){1'b0}}, cmp_o};
    endcase
  end

  ////////////////////////////////////////
  // Ready
  ////////////////////////////////////////

  // Low for the first cycle after reset, then always high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      op_valid_q <= 1'b0;
    end else begin
      op_valid_q <= 1'b1;
    end
  end

  assign ready_o = op_valid_q;

endmodule

//--- design/ex_mult.sv
////////////////////////////////////////
// One multiplier replica, instantiated three times behind the voter
// MUL answers at once, MULH takes a second cycle
////////////////////////////////////////
`timescale 1ns/1ps

module ex_mult (
  input  logic              clk,
  input  logic              rst_n,
  input  ex_pkg::mult_req_t req_i,
  input  logic              ex_ready_i,
  output ex_pkg::mult_rsp_t rsp_o
);
  import ex_pkg::*;

  // MULH sequence state
  typedef enum logic {
    st_idle = 1'b0,
    st_high = 1'b1
  } mulh_state_e;

  mulh_state_e              state_q;
  mulh_state_e              state_d;
  // Full signed product of a and b
  logic signed [2*xlen-1:0] product;
  // High word kept for the second MULH cycle
  logic [xlen-1:0]          high_q;
  // First enabled cycle of a MULH
  logic                     start_mulh;

  assign product    = $signed(req_i.a) * $signed(req_i.b);
  assign start_mulh = req_i.en && (req_i.op == mult_mulh) && (state_q == st_idle);

  ////////////////////////////////////////
  // MULH sequence
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (start_mulh) begin
          state_d = st_high;
        end
      end
      // Wait here while the stage is stalled
      st_high: begin
        if (ex_ready_i) begin
          state_d = st_idle;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture the high word on the first cycle
  always_ff @(posedge clk) begin
    if (start_mulh) begin
      high_q <= product[2*xlen-1:xlen];
    end
  end

  ////////////////////////////////////////
  // Response
  ////////////////////////////////////////

  always_comb begin
    rsp_o.mulh_active = (state_q == st_high);
    if (state_q == st_high) begin
      rsp_o.result = high_q;
      rsp_o.ready  = 1'b1;
    end else begin
      // Low word for MUL, not ready on a starting MULH
      rsp_o.result = product[xlen-1:0];
      rsp_o.ready  = !start_mulh;
    end
  end

endmodule

//--- design/mult_tmr_voter.sv
////////////////////////////////////////
// Majority voter over the three multiplier replicas
// Combinational, flags any disagreement
////////////////////////////////////////
`timescale 1ns/1ps

module mult_tmr_voter (
  input  ex_pkg::mult_rsp_t rsp_a_i,
  input  ex_pkg::mult_rsp_t rsp_b_i,
  input  ex_pkg::mult_rsp_t rsp_c_i,
  output ex_pkg::mult_rsp_t rsp_o,
  output logic              fault_o
);

  // Pairwise agreement over the whole response
  logic ab_eq;
  logic bc_eq;
  logic ac_eq;

  assign ab_eq = (rsp_a_i == rsp_b_i);
  assign bc_eq = (rsp_b_i == rsp_c_i);
  assign ac_eq = (rsp_a_i == rsp_c_i);

  ////////////////////////////////////////
  // Vote
  ////////////////////////////////////////

  // Any agreeing pair wins
  always_comb begin
    if (ab_eq) begin
      rsp_o = rsp_a_i;
    end else if (bc_eq) begin
      rsp_o = rsp_b_i;
    end else if (ac_eq) begin
      rsp_o = rsp_a_i;
    end else begin
      // No majority, so report not ready and stall the stage
      rsp_o = '0;
    end
  end

  ////////////////////////////////////////
  // Fault flag
  ////////////////////////////////////////

  // Set whenever one replica or more differs
  assign fault_o = !(ab_eq && bc_eq);

endmodule

//--- design/ex_writeback.sv
////////////////////////////////////////
// Forwarding port, EX/WB load register and stall handshake
// Sits between the functional units and the writeback stage
////////////////////////////////////////
`timescale 1ns/1ps

module ex_writeback (
  input  logic                          clk,
  input  logic                          rst_n,
  // Functional unit results
  input  logic [ex_pkg::xlen-1:0]       alu_result_i,
  input  ex_pkg::mult_rsp_t             mult_rsp_i,
  input  logic                          alu_ready_i,
  input  logic                          alu_en_i,
  input  logic                          mult_en_i,
  // CSR read data
  input  logic                          csr_access_i,
  input  logic [ex_pkg::xlen-1:0]       csr_rdata_i,
  // ALU write request from decode
  input  logic                          regfile_alu_we_i,
  input  logic [ex_pkg::reg_addr_w-1:0] regfile_alu_waddr_i,
  // Load write request from decode
  input  logic                          regfile_we_i,
  input  logic [ex_pkg::reg_addr_w-1:0] regfile_waddr_i,
  // Load/store unit
  input  logic                          lsu_en_i,
  input  logic                          lsu_ready_i,
  input  logic [ex_pkg::xlen-1:0]       lsu_rdata_i,
  // Stall control
  input  logic                          branch_in_ex_i,
  input  logic                          wb_ready_i,
  output ex_pkg::reg_wr_t               fwd_wr_o,
  output ex_pkg::reg_wr_t               wb_wr_o,
  output logic                          ex_ready_o,
  output logic                          ex_valid_o
);
  import ex_pkg::*;

  // Selected forwarding data
  logic [xlen-1:0]       fwd_data;
  // Pending load write
  logic                  lsu_we_q;
  logic [reg_addr_w-1:0] lsu_waddr_q;

  ////////////////////////////////////////
  // Forwarding port
  ////////////////////////////////////////

  // CSR first, then multiplier, then ALU
  always_comb begin
    if (csr_access_i) begin
      fwd_data = csr_rdata_i;
    end else if (mult_en_i) begin
      fwd_data = mult_rsp_i.result;
    end else if (alu_en_i) begin
      fwd_data = alu_result_i;
    end else begin
      fwd_data = '0;
    end
  end

  assign fwd_wr_o.we   = regfile_alu_we_i;
  assign fwd_wr_o.addr = regfile_alu_waddr_i;
  assign fwd_wr_o.data = fwd_data;

  ////////////////////////////////////////
  // EX/WB load register
  ////////////////////////////////////////

  // ex_valid_o already includes wb_ready_i
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_we_q <= 1'b0;
    end else if (ex_valid_o) begin
      lsu_we_q <= regfile_we_i;
    end else if (wb_ready_i) begin
      // Nothing new, so flush the old write
      lsu_we_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_o) begin
      lsu_waddr_q <= regfile_waddr_i;
    end
  end

  // Load data arrives the cycle after the request
  assign wb_wr_o.we   = lsu_we_q;
  assign wb_wr_o.addr = lsu_waddr_q;
  assign wb_wr_o.data = lsu_rdata_i;

  ////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////

  // Branches finish here without writeback
  assign ex_ready_o = (mult_rsp_i.ready && lsu_ready_i && wb_ready_i) || branch_in_ex_i;

  // Valid goes forward and never looks at ex_ready_o
  assign ex_valid_o = (alu_en_i || mult_en_i || csr_access_i || lsu_en_i) &&
                      alu_ready_i && mult_rsp_i.ready && lsu_ready_i && wb_ready_i;

endmodule

//--- design/ex_stage.sv
////////////////////////////////////////
// Execute stage top with ALU, triplicated multiplier and writeback
// Decode drives the requests, writeback takes the two ports
////////////////////////////////////////
`timescale 1ns/1ps

module ex_stage (
  input  logic                          clk,
  input  logic                          rst_n,
  // Requests from decode
  input  ex_pkg::alu_req_t              alu_req_i,
  input  ex_pkg::mult_req_t             mult_req_i,
  input  logic                          csr_access_i,
  input  logic [ex_pkg::xlen-1:0]       csr_rdata_i,
  input  logic                          regfile_alu_we_i,
  input  logic [ex_pkg::reg_addr_w-1:0] regfile_alu_waddr_i,
  input  logic                          regfile_we_i,
  input  logic [ex_pkg::reg_addr_w-1:0] regfile_waddr_i,
  // Load/store unit
  input  logic                          lsu_en_i,
  input  logic                          lsu_ready_i,
  input  logic [ex_pkg::xlen-1:0]       lsu_rdata_i,
  // Stall control
  input  logic                          branch_in_ex_i,
  input  logic                          wb_ready_i,
  // Write ports
  output ex_pkg::reg_wr_t               fwd_wr_o,
  output ex_pkg::reg_wr_t               wb_wr_o,
  // Branch to fetch
  output logic                          branch_decision_o,
  output logic [ex_pkg::xlen-1:0]       jump_target_o,
  output logic                          ex_ready_o,
  output logic                          ex_valid_o,
  output logic                          tmr_fault_o
);
  import ex_pkg::*;

  logic [xlen-1:0] alu_result;
  logic            alu_ready;
  // One response per replica, then the voted one
  mult_rsp_t       rsp_rep [3];
  mult_rsp_t       mult_rsp;

  ////////////////////////////////////////
  // ALU and branch
  ////////////////////////////////////////

  ex_alu u_alu (
    .clk     (clk),
    .rst_n   (rst_n),
    .req_i   (alu_req_i),
    .result_o(alu_result),
    .cmp_o   (branch_decision_o),
    .ready_o (alu_ready)
  );

  // Target computed in decode, carried on operand c
  assign jump_target_o = alu_req_i.c;

  ////////////////////////////////////////
  // Triplicated multiplier
  ////////////////////////////////////////

  for (genvar i = 0; i < 3; i++) begin : gen_mult
    ex_mult u_mult (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_i     (mult_req_i),
      .ex_ready_i(ex_ready_o),
      .rsp_o     (rsp_rep[i])
    );
  end

  mult_tmr_voter u_voter (
    .rsp_a_i(rsp_rep[0]),
    .rsp_b_i(rsp_rep[1]),
    .rsp_c_i(rsp_rep[2]),
    .rsp_o  (mult_rsp),
    .fault_o(tmr_fault_o)
  );

  ////////////////////////////////////////
  // Write ports and handshake
  ////////////////////////////////////////

  ex_writeback u_writeback (
    .clk                (clk),
    .rst_n              (rst_n),
    .alu_result_i       (alu_result),
    .mult_rsp_i         (mult_rsp),
    .alu_ready_i        (alu_ready),
    .alu_en_i           (alu_req_i.en),
    .mult_en_i          (mult_req_i.en),
    .csr_access_i       (csr_access_i),
    .csr_rdata_i        (csr_rdata_i),
    .regfile_alu_we_i   (regfile_alu_we_i),
    .regfile_alu_waddr_i(regfile_alu_waddr_i),
    .regfile_we_i       (regfile_we_i),
    .regfile_waddr_i    (regfile_waddr_i),
    .lsu_en_i           (lsu_en_i),
    .lsu_ready_i        (lsu_ready_i),
    .lsu_rdata_i        (lsu_rdata_i),
    .branch_in_ex_i     (branch_in_ex_i),
    .wb_ready_i         (wb_ready_i),
    .fwd_wr_o           (fwd_wr_o),
    .wb_wr_o            (wb_wr_o),
    .ex_ready_o         (ex_ready_o),
    .ex_valid_o         (ex_valid_o)
  );

endmodule

//--- test/ex_checker.sv
////////////////////////////////////////
// Watches the execute stage outputs and compares them
// The testbench calls its tasks at stable sample points
////////////////////////////////////////
`timescale 1ns/1ps

module ex_checker (
  input  ex_pkg::reg_wr_t         fwd_wr_i,
  input  ex_pkg::reg_wr_t         wb_wr_i,
  input  logic                    branch_decision_i,
  input  logic [ex_pkg::xlen-1:0] jump_target_i,
  input  logic                    ex_ready_i,
  input  logic                    ex_valid_i,
  input  logic                    tmr_fault_i,
  output int                      err_cnt_o
);
  import ex_pkg::*;

  int err_cnt = 0;
  // Error count when the current test began
  int err_base = 0;
  int pass_cnt = 0;
  int fail_cnt = 0;

  assign err_cnt_o = err_cnt;

  task automatic compare(input string what, input logic [xlen-1:0] exp,
                         input logic [xlen-1:0] got);
    if (got !== exp) begin
      $display("error at %0t ns: %s expected %0h, got %0h", $time, what, exp, got);
      err_cnt++;
    end
  endtask

  task automatic start_test();
    err_base = err_cnt;
  endtask

  // Forwarding port and branch outputs in the valid cycle
  task automatic check_exec(input logic [reg_addr_w-1:0] addr, input logic [xlen-1:0] data,
                            input logic cmp, input logic [xlen-1:0] target,
                            input logic fault);
    compare("ex_valid_o", 1, ex_valid_i);
    compare("fwd_wr_o.we", 1, fwd_wr_i.we);
    compare("fwd_wr_o.addr", addr, fwd_wr_i.addr);
    compare("fwd_wr_o.data", data, fwd_wr_i.data);
    compare("branch_decision_o", cmp, branch_decision_i);
    compare("jump_target_o", target, jump_target_i);
    compare("tmr_fault_o", fault, tmr_fault_i);
  endtask

  // Stalled cycle, nothing may complete
  task automatic check_blocked(input logic fault);
    compare("ex_valid_o while stalled", 0, ex_valid_i);
    compare("ex_ready_o while stalled", 0, ex_ready_i);
    compare("wb_wr_o.we while stalled", 0, wb_wr_i.we);
    compare("tmr_fault_o while stalled", fault, tmr_fault_i);
  endtask

  task automatic check_load(input logic [reg_addr_w-1:0] addr, input logic [xlen-1:0] data);
    compare("wb_wr_o.we", 1, wb_wr_i.we);
    compare("wb_wr_o.addr", addr, wb_wr_i.addr);
    compare("wb_wr_o.data", data, wb_wr_i.data);
  endtask

  task automatic check_stall(input int exp, input int got);
    compare("cycles with ex_ready_o low", exp, got);
  endtask

  task automatic end_test(input int idx, input string name);
    if (err_cnt == err_base) begin
      pass_cnt++;
      $display("test %0d %s: passed", idx, name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: failed with %0d errors", idx, name, err_cnt - err_base);
    end
  endtask

  task automatic report();
    $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
             pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
  endtask

endmodule

//--- test/ex_assert.sv
////////////////////////////////////////
// Handshake and load port assertions, bound into ex_writeback
////////////////////////////////////////
`timescale 1ns/1ps

module ex_assert (
  input logic            clk,
  input logic            rst_n,
  input logic            ex_valid_i,
  input logic            wb_ready_i,
  input ex_pkg::reg_wr_t wb_wr_i
);

  // Count of failed assertions
  int err_cnt = 0;

  // Valid only when writeback can accept
  valid_needs_wb: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_i |-> wb_ready_i)
    else begin
      $error("ex_valid_o high while wb_ready_i low");
      err_cnt++;
    end

  // No load write while in reset
  load_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !wb_wr_i.we)
    else begin
      $error("wb_wr_o.we high during reset");
      err_cnt++;
    end

  // A load write comes from a valid cycle, or is held by back-pressure
  load_after_valid: assert property (@(posedge clk) disable iff (!rst_n)
    wb_wr_i.we |-> ($past(ex_valid_i) || $past(wb_wr_i.we && !wb_ready_i)))
    else begin
      $error("wb_wr_o.we without ex_valid_o in the cycle before");
      err_cnt++;
    end

endmodule

bind ex_writeback ex_assert u_assert (
  .clk       (clk),
  .rst_n     (rst_n),
  .ex_valid_i(ex_valid_o),
  .wb_ready_i(wb_ready_i),
  .wb_wr_i   (wb_wr_o)
);

//--- test/tb_ex_stage.sv
////////////////////////////////////////
// Testbench for the execute stage
// Applies a table of operations and leaves the comparing to ex_checker
////////////////////////////////////////
`timescale 1ns/1ps

module tb_ex_stage;
  import ex_pkg::*;

  // Kind of operation in one table row
  typedef enum logic [1:0] {
    k_alu,
    k_mul,
    k_csr,
    k_load
  } kind_e;

  // One stimulus row with its expected values
  typedef struct {
    kind_e           kind;
    logic [3:0]      op;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    // CSR read data or load data
    logic [xlen-1:0] aux;
    logic            wb_rdy;
    // 0 none, 1 one replica wrong, 2 all three differ
    logic [1:0]      fault;
    logic [xlen-1:0] exp_data;
    logic            exp_cmp;
  } row_t;

  localparam logic [3:0] op_mul  = 4'd0;
  localparam logic [3:0] op_mulh = 4'd1;
  // Cycles allowed for ex_valid_o to rise
  localparam int valid_timeout = 8;
  // Cycles a blocked row is held before release
  localparam int block_cycles = 3;
  // Wrong replica responses, all different and all ready
  localparam mult_rsp_t bad_a = {32'hdead_beef, 1'b1, 1'b0};
  localparam mult_rsp_t bad_b = {32'h1111_1111, 1'b1, 1'b0};
  localparam mult_rsp_t bad_c = {32'h2222_2222, 1'b1, 1'b0};

  logic                  clk;
  logic                  rst_n;
  alu_req_t              alu_req;
  mult_req_t             mult_req;
  logic                  csr_access;
  logic [xlen-1:0]       csr_rdata;
  logic                  regfile_alu_we;
  logic [reg_addr_w-1:0] regfile_alu_waddr;
  logic                  regfile_we;
  logic [reg_addr_w-1:0] regfile_waddr;
  logic                  lsu_en;
  logic                  lsu_ready;
  logic [xlen-1:0]       lsu_rdata;
  logic                  branch_in_ex;
  logic                  wb_ready;
  reg_wr_t               fwd_wr;
  reg_wr_t               wb_wr;
  logic                  branch_decision;
  logic [xlen-1:0]       jump_target;
  logic                  ex_ready;
  logic                  ex_valid;
  logic                  tmr_fault;
  int                    chk_errors;
  row_t                  rows[$];
  logic                  timed_out;

  ex_stage uut (
    .clk                (clk),
    .rst_n              (rst_n),
    .alu_req_i          (alu_req),
    .mult_req_i         (mult_req),
    .csr_access_i       (csr_access),
    .csr_rdata_i        (csr_rdata),
    .regfile_alu_we_i   (regfile_alu_we),
    .regfile_alu_waddr_i(regfile_alu_waddr),
    .regfile_we_i       (regfile_we),
    .regfile_waddr_i    (regfile_waddr),
    .lsu_en_i           (lsu_en),
    .lsu_ready_i        (lsu_ready),
    .lsu_rdata_i        (lsu_rdata),
    .branch_in_ex_i     (branch_in_ex),
    .wb_ready_i         (wb_ready),
    .fwd_wr_o           (fwd_wr),
    .wb_wr_o            (wb_wr),
    .branch_decision_o  (branch_decision),
    .jump_target_o      (jump_target),
    .ex_ready_o         (ex_ready),
    .ex_valid_o         (ex_valid),
    .tmr_fault_o        (tmr_fault)
  );

  ex_checker u_chk (
    .fwd_wr_i         (fwd_wr),
    .wb_wr_i          (wb_wr),
    .branch_decision_i(branch_decision),
    .jump_target_i    (jump_target),
    .ex_ready_i       (ex_ready),
    .ex_valid_i       (ex_valid),
    .tmr_fault_i      (tmr_fault),
    .err_cnt_o        (chk_errors)
  );

  // 40 ns clock
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////
  // Reference models
  ////////////////////////////////////////

  // Result of one ALU opcode where comparisons give 0 or 1
  function automatic logic [xlen-1:0] alu_model(input logic [3:0] op,
                                                input logic [xlen-1:0] a,
                                                input logic [xlen-1:0] b);
    logic [4:0] sh;
    logic       lt_s;
    logic       lt_u;
    sh   = b[4:0];
    lt_u = (a < b);
    // Signs differ, so the negative one is smaller
    lt_s = (a[31] != b[31]) ? a[31] : lt_u;
    case (alu_op_e'(op))
      alu_add:         return a + b;
      alu_sub:         return a + ~b + 32'd1;
      alu_and:         return a & b;
      alu_or:          return a | b;
      alu_xor:         return a ^ b;
      alu_sll:         return a << sh;
      alu_srl:         return a >> sh;
      alu_sra:         return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
      alu_slt, alu_lt: return {31'b0, lt_s};
      alu_sltu:        return {31'b0, lt_u};
      alu_eq:          return {31'b0, a == b};
      alu_ne:          return {31'b0, a != b};
      alu_ge:          return {31'b0, !lt_s};
      default:         return 32'h0;
    endcase
  endfunction

  // Low or signed high word of the product
  function automatic logic [xlen-1:0] mul_model(input logic [3:0] op,
                                                input logic [xlen-1:0] a,
                                                input logic [xlen-1:0] b);
    logic [2*xlen-1:0] p;
    p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
    return (op == op_mulh) ? p[63:32] : p[31:0];
  endfunction

  ////////////////////////////////////////
  // Table
  ////////////////////////////////////////

  function automatic row_t mk(input kind_e kind, input logic [3:0] op,
                              input logic [xlen-1:0] a, input logic [xlen-1:0] b,
                              input logic [xlen-1:0] aux, input logic wb_rdy,
                              input logic [1:0] fault, input logic [xlen-1:0] exp_data,
                              input logic exp_cmp);
    row_t r;
    r.kind     = kind;
    r.op       = op;
    r.a        = a;
    r.b        = b;
    r.aux      = aux;
    r.wb_rdy   = wb_rdy;
    r.fault    = fault;
    r.exp_data = exp_data;
    r.exp_cmp  = exp_cmp;
    return r;
  endfunction

  // Random operands with expected values from the models
  function automatic row_t mk_rand(input kind_e kind, input logic [3:0] op);
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] res;
    a = $urandom;
    b = $urandom;
    if (kind == k_mul) begin
      return mk(kind, op, a, b, 0, 1, 0, mul_model(op, a, b), 1'b0);
    end
    res = alu_model(op, a, b);
    return mk(kind, op, a, b, 0, 1, 0, res, (op >= 4'(alu_slt)) ? res[0] : 1'b0);
  endfunction

  task automatic build_table();
    // One row per ALU opcode
    rows.push_back(mk(k_alu, alu_add, 32'h5, 32'h3, 0, 1, 0, 32'h8, 0));
    rows.push_back(mk(k_alu, alu_sub, 32'h5, 32'h7, 0, 1, 0, 32'hffff_fffe, 0));
    rows.push_back(mk(k_alu, alu_and, 32'hf0f0_f0f0, 32'h0ff0_0ff0, 0, 1, 0, 32'h00f0_00f0, 0));
    rows.push_back(mk(k_alu, alu_or, 32'hf0f0_f0f0, 32'h0ff0_0ff0, 0, 1, 0, 32'hfff0_fff0, 0));
    rows.push_back(mk(k_alu, alu_xor, 32'hf0f0_f0f0, 32'h0ff0_0ff0, 0, 1, 0, 32'hff00_ff00, 0));
    // Shift amount uses only the low 5 bits of b
    rows.push_back(mk(k_alu, alu_sll, 32'h1, 32'h24, 0, 1, 0, 32'h10, 0));
    rows.push_back(mk(k_alu, alu_srl, 32'h8000_0000, 32'h4, 0, 1, 0, 32'h0800_0000, 0));
    rows.push_back(mk(k_alu, alu_sra, 32'h8000_0000, 32'h4, 0, 1, 0, 32'hf800_0000, 0));
    rows.push_back(mk(k_alu, alu_slt, 32'hffff_ffff, 32'h1, 0, 1, 0, 32'h1, 1));
    rows.push_back(mk(k_alu, alu_sltu, 32'hffff_ffff, 32'h1, 0, 1, 0, 32'h0, 0));
    // Branch comparisons
    rows.push_back(mk(k_alu, alu_eq, 32'h1234_5678, 32'h1234_5678, 0, 1, 0, 32'h1, 1));
    rows.push_back(mk(k_alu, alu_ne, 32'h1234_5678, 32'h1234_5678, 0, 1, 0, 32'h0, 0));
    rows.push_back(mk(k_alu, alu_lt, 32'hffff_fff0, 32'h10, 0, 1, 0, 32'h1, 1));
    rows.push_back(mk(k_alu, alu_ge, 32'hffff_fff0, 32'h10, 0, 1, 0, 32'h0, 0));
    // Multiplier rows where MULH takes two cycles
    rows.push_back(mk(k_mul, op_mul, 32'h6, 32'hffff_fffd, 0, 1, 0, 32'hffff_ffee, 0));
    rows.push_back(mk(k_mul, op_mulh, 32'h8000_0000, 32'h2, 0, 1, 0, 32'hffff_ffff, 0));
    rows.push_back(mk(k_mul, op_mulh, 32'h0001_0000, 32'h0001_0000, 0, 1, 0, 32'h1, 0));
    // Replica faults
    rows.push_back(mk(k_mul, op_mul, 32'h64, 32'h3, 0, 1, 1, 32'h12c, 0));
    rows.push_back(mk(k_mul, op_mul, 32'h9, 32'h9, 0, 1, 2, 32'h51, 0));
    // CSR wins over ALU and multiplier
    rows.push_back(mk(k_csr, alu_add, 32'h5, 32'h3, 32'hcafe_f00d, 1, 0, 32'hcafe_f00d, 0));
    // Two loads with the second under back-pressure
    rows.push_back(mk(k_load, 4'd0, 32'h0, 32'h0, 32'h1357_9bdf, 1, 0, 32'h0, 0));
    rows.push_back(mk(k_load, 4'd0, 32'h0, 32'h0, 32'h2468_ace0, 0, 0, 32'h0, 0));
    rows.push_back(mk_rand(k_alu, 4'($urandom % 14)));
    rows.push_back(mk_rand(k_alu, 4'($urandom % 14)));
    rows.push_back(mk_rand(k_mul, op_mul));
    rows.push_back(mk_rand(k_mul, op_mulh));
  endtask

  ////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////

  // Load data is left alone so the WB port keeps it
  task automatic drive_idle();
    alu_req           = '0;
    mult_req          = '0;
    csr_access        = 1'b0;
    csr_rdata         = '0;
    regfile_alu_we    = 1'b0;
    regfile_alu_waddr = '0;
    regfile_we        = 1'b0;
    regfile_waddr     = '0;
    lsu_en            = 1'b0;
    lsu_ready         = 1'b1;
    branch_in_ex      = 1'b0;
    wb_ready          = 1'b1;
  endtask

  task automatic drive_row(input row_t r, input logic [reg_addr_w-1:0] addr,
                           input logic [xlen-1:0] target);
    alu_req.c = target;
    if (r.kind == k_alu || r.kind == k_csr) begin
      alu_req.en = 1'b1;
      alu_req.op = alu_op_e'(r.op);
      alu_req.a  = r.a;
      alu_req.b  = r.b;
    end
    if (r.kind == k_mul || r.kind == k_csr) begin
      mult_req.en = 1'b1;
      mult_req.op = mult_op_e'(r.op[0]);
      mult_req.a  = r.a;
      mult_req.b  = r.b;
    end
    if (r.kind == k_csr) begin
      csr_access = 1'b1;
      csr_rdata  = r.aux;
    end
    if (r.kind == k_load) begin
      lsu_en        = 1'b1;
      regfile_we    = 1'b1;
      regfile_waddr = addr;
      lsu_rdata     = r.aux;
    end else begin
      regfile_alu_we    = 1'b1;
      regfile_alu_waddr = addr;
    end
    wb_ready = r.wb_rdy;
  endtask

  task automatic release_voter();
    release uut.u_voter.rsp_a_i;
    release uut.u_voter.rsp_b_i;
    release uut.u_voter.rsp_c_i;
  endtask

  // Counts cycles with ex_ready_o low before ex_valid_o
  task automatic wait_valid(input int idx, output int stall);
    int   cycles;
    logic seen;
    stall  = 0;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < valid_timeout) begin
      @(negedge clk);
      cycles++;
      if (ex_valid) begin
        seen = 1'b1;
      end else if (!ex_ready) begin
        stall++;
      end
    end
    if (!seen) begin
      $display("timeout: ex_valid_o did not rise within %0d cycles in test %0d",
               valid_timeout, idx);
      timed_out = 1'b1;
    end
  endtask

  ////////////////////////////////////////
  // One row
  ////////////////////////////////////////

  task automatic apply_row(input int idx);
    row_t                  r;
    logic [reg_addr_w-1:0] addr;
    logic [xlen-1:0]       target;
    int                    stall;
    r      = rows[idx];
    addr   = reg_addr_w'(idx + 1);
    target = 32'h0000_1000 + 32'(idx * 4);
    u_chk.start_test();
    @(posedge clk);
    #2;
    drive_row(r, addr, target);
    if (r.fault != 0) begin
      force uut.u_voter.rsp_a_i = bad_a;
    end
    if (r.fault == 2) begin
      force uut.u_voter.rsp_b_i = bad_b;
      force uut.u_voter.rsp_c_i = bad_c;
    end
    // No majority or no writeback, so the stage must stall
    if (r.fault == 2 || !r.wb_rdy) begin
      repeat (block_cycles) begin
        @(negedge clk);
        u_chk.check_blocked(r.fault == 2);
      end
      @(posedge clk);
      #2;
      wb_ready = 1'b1;
      release_voter();
    end
    wait_valid(idx, stall);
    if (!timed_out) begin
      if (r.kind != k_load) begin
        u_chk.check_exec(addr, r.exp_data, r.exp_cmp, target, r.fault == 1);
      end
      u_chk.check_stall((r.kind == k_mul && r.op == op_mulh) ? 1 : 0, stall);
      @(posedge clk);
      #2;
      drive_idle();
      release_voter();
      // Load write shows one cycle after ex_valid_o
      if (r.kind == k_load) begin
        @(negedge clk);
        u_chk.check_load(addr, r.aux);
      end
      u_chk.end_test(idx, r.kind.name());
    end
  endtask

  initial begin
    void'($urandom(60005));
    timed_out = 1'b0;
    rst_n     = 1'b0;
    lsu_rdata = '0;
    drive_idle();
    build_table();
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (int i = 0; i < rows.size() && !timed_out; i++) begin
      apply_row(i);
    end
    u_chk.report();
    if (timed_out || chk_errors != 0 || uut.u_writeback.u_assert.err_cnt != 0) begin
      $display("Test FAILED");
    end else begin
      $display("Test OK");
    end
    $finish;
  end

endmodule

//--- tb.f
design/ex_pkg.sv
design/ex_alu.sv
design/ex_mult.sv
design/mult_tmr_voter.sv
design/ex_writeback.sv
design/ex_stage.sv
test/ex_checker.sv
test/ex_assert.sv
test/tb_ex_stage.sv

//--- Makefile
# Verilator build and run of the execute stage testbench
TOP := tb_ex_stage
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Test OK" $(LOG) || (echo "simulation ended early"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
